// ==== vlog.f ====
logic/noc_pkg.sv
logic/packet_splitter.sv
logic/flit_arbiter.sv
logic/packet_assembler.sv
logic/noc_injection_top.sv
testbench/tb_noc_injection.sv

// ==== testbench/tb_noc_injection.sv ====
`timescale 1ns/1ns

module tb_noc_injection import noc_pkg::*; ();

    localparam int RANDOM_CYCLES  = 40;
    localparam int BURST_CYCLES   = 12;
    localparam int NUM_PACKETS    = 1 + 10 + SRC_COUNT * RANDOM_CYCLES + BURST_CYCLES;
    localparam int TIMEOUT_CYCLES = NUM_PACKETS * 40 + 200;
    localparam int LONE_LATENCY   = 7;

    logic                       clk;
    logic                       rst_n;
    logic [SRC_COUNT-1:0]       packet_valid;
    packet_t [SRC_COUNT-1:0]    packet_data;
    node_id_t [SRC_COUNT-1:0]   packet_dest;
    packet_id_t [SRC_COUNT-1:0] packet_id;
    logic [SRC_COUNT-1:0]       full;
    logic                       deliver_valid;
    packet_t                    deliver_data;
    node_id_t                   deliver_src;
    coord_t                     deliver_dest;
    packet_id_t                 deliver_id;

    // Expected packets, oldest first, searched by source
    node_id_t   exp_src   [$];
    packet_t    exp_data  [$];
    coord_t     exp_coord [$];
    packet_id_t exp_id    [$];
    int         exp_cycle [$];

    int          cycle = 0;
    int          value_errors;
    int          other_errors;
    logic [31:0] lcg_state;
    logic        idle_check;
    logic        latency_check;
    logic        saw_full;

    noc_injection_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .packet_valid  (packet_valid),
        .packet_data   (packet_data),
        .packet_dest   (packet_dest),
        .packet_id     (packet_id),
        .full          (full),
        .deliver_valid (deliver_valid),
        .deliver_data  (deliver_data),
        .deliver_src   (deliver_src),
        .deliver_dest  (deliver_dest),
        .deliver_id    (deliver_id)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Column = node mod 3 in bits 3:2, row = node div 3 in bits 1:0
    function automatic coord_t map_coord(node_id_t node);
        int col;
        int row;
        col = int'(node) % 3;
        row = int'(node) / 3;
        if (node > 4'd8) begin
            return 4'hF;
        end
        return {col[1:0], row[1:0]};
    endfunction

    task automatic compare_field(string name, logic [PACKET_W-1:0] got,
                                 logic [PACKET_W-1:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_delivery();
        int idx;
        idx = -1;
        for (int i = 0; i < exp_src.size(); i++) begin
            if (idx < 0 && exp_src[i] == deliver_src) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            other_errors++;
            $display("Packet delivered from source %0d with none expected", deliver_src);
            return;
        end
        compare_field("deliver_data", deliver_data, exp_data[idx]);
        compare_field("deliver_dest", deliver_dest, exp_coord[idx]);
        compare_field("deliver_id", deliver_id, exp_id[idx]);
        if (latency_check) begin
            assert (cycle - exp_cycle[idx] == LONE_LATENCY) else begin
                other_errors++;
                $display("Lone packet took %0d cycles instead of %0d",
                         cycle - exp_cycle[idx], LONE_LATENCY);
            end
        end
        exp_src.delete(idx);
        exp_data.delete(idx);
        exp_coord.delete(idx);
        exp_id.delete(idx);
        exp_cycle.delete(idx);
    endtask

    // Deliveries are checked before this edge's entries are recorded
    always @(posedge clk) begin
        cycle++;
        if (rst_n) begin
            if (idle_check) begin
                assert (!deliver_valid && full == '0) else begin
                    other_errors++;
                    $display("deliver_valid or full went high with no packet offered");
                end
            end
            if (full[0]) begin
                saw_full = 1'b1;
            end
            if (deliver_valid) begin
                check_delivery();
            end
            for (int s = 0; s < SRC_COUNT; s++) begin
                if (packet_valid[s] && !full[s]) begin
                    exp_src.push_back(node_id_t'(s));
                    exp_data.push_back(packet_data[s]);
                    exp_coord.push_back(map_coord(packet_dest[s]));
                    exp_id.push_back(packet_id[s]);
                    exp_cycle.push_back(cycle);
                end
            end
        end
    end

    task automatic load_source(int src, node_id_t dest);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        r0 = next_rand();
        r1 = next_rand();
        r2 = next_rand();
        packet_valid[src] = 1'b1;
        packet_data[src]  = {r2[31:28], r1, r0};
        packet_dest[src]  = dest;
        packet_id[src]    = r2[20:16];
    endtask

    task automatic wait_drained();
        while (exp_src.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic report_undelivered();
        for (int i = 0; i < exp_src.size(); i++) begin
            other_errors++;
            $display("Packet id 0x%0h from source %0d was never delivered",
                     exp_id[i], exp_src[i]);
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
    endtask

    initial begin
        logic [31:0] r;
        rst_n         = 1'b0;
        packet_valid  = '0;
        packet_data   = '0;
        packet_dest   = '0;
        packet_id     = '0;
        lcg_state     = 32'h5f8d;
        idle_check    = 1'b1;
        latency_check = 1'b0;
        saw_full      = 1'b0;
        value_errors  = 0;
        other_errors  = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (10) @(negedge clk);
        idle_check = 1'b0;

        latency_check = 1'b1;
        load_source(1, 4'd5);
        @(negedge clk);
        packet_valid = '0;
        wait_drained();
        latency_check = 1'b0;

        // Nodes 0 to 8, then one beyond the mesh
        for (int i = 0; i < 10; i++) begin
            packet_valid = '0;
            load_source(i % SRC_COUNT, (i < 9) ? node_id_t'(i) : 4'd12);
            @(negedge clk);
        end
        packet_valid = '0;
        wait_drained();

        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            packet_valid = '0;
            for (int s = 0; s < SRC_COUNT; s++) begin
                r = next_rand();
                if (r[27]) begin
                    load_source(s, node_id_t'(r[23:20]));
                end
            end
            @(negedge clk);
        end
        packet_valid = '0;
        wait_drained();

        saw_full = 1'b0;
        for (int c = 0; c < BURST_CYCLES; c++) begin
            r = next_rand();
            load_source(0, node_id_t'(r[23:20]));
            @(negedge clk);
        end
        packet_valid = '0;
        wait_drained();
        assert (saw_full) else begin
            other_errors++;
            $display("full on source 0 never rose during the burst");
        end

        print_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        other_errors++;
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_undelivered();
        print_counts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== logic/noc_injection_top.sv ====
`timescale 1ns/1ns

module noc_injection_top import noc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [SRC_COUNT-1:0]       packet_valid,
    input  packet_t [SRC_COUNT-1:0]    packet_data,
    input  node_id_t [SRC_COUNT-1:0]   packet_dest,
    input  packet_id_t [SRC_COUNT-1:0] packet_id,
    output logic [SRC_COUNT-1:0]       full,
    output logic                       deliver_valid,
    output packet_t                    deliver_data,
    output node_id_t                   deliver_src,
    output coord_t                     deliver_dest,
    output packet_id_t                 deliver_id
);

    logic [SRC_COUNT-1:0]  flit_valid;
    logic [SRC_COUNT-1:0]  take;
    flit_t [SRC_COUNT-1:0] flit;
    logic                  link_valid;
    flit_t                 link_flit;

    // Source s injects as node s
    for (genvar s = 0; s < SRC_COUNT; s++) begin : g_src
        packet_splitter splitter_inst (
            .clk          (clk),
            .rst_n        (rst_n),
            .node_id      (node_id_t'(s)),
            .packet_valid (packet_valid[s]),
            .packet_data  (packet_data[s]),
            .packet_dest  (packet_dest[s]),
            .packet_id    (packet_id[s]),
            .full         (full[s]),
            .flit_valid   (flit_valid[s]),
            .flit         (flit[s]),
            .take         (take[s])
        );
    end

    flit_arbiter arbiter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .flit_valid (flit_valid),
        .flit       (flit),
        .take       (take),
        .link_valid (link_valid),
        .link_flit  (link_flit)
    );

    packet_assembler assembler_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .link_valid    (link_valid),
        .link_flit     (link_flit),
        .deliver_valid (deliver_valid),
        .deliver_data  (deliver_data),
        .deliver_src   (deliver_src),
        .deliver_dest  (deliver_dest),
        .deliver_id    (deliver_id)
    );

endmodule

// ==== logic/packet_assembler.sv ====
`timescale 1ns/1ns

module packet_assembler import noc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       link_valid,
    input  flit_t      link_flit,
    output logic       deliver_valid,
    output packet_t    deliver_data,
    output node_id_t   deliver_src,
    output coord_t     deliver_dest,
    output packet_id_t deliver_id
);

    // One partial packet per source
    packet_t slot [SRC_COUNT];

    coord_t           link_coord;
    payload_t         link_payload;
    packet_id_t       link_id;
    node_id_t         link_src;
    flit_idx_t        link_idx;
    logic [SRC_W-1:0] slot_sel;
    logic             last_flit;
    packet_t          merged;

    // Unpack the flit fields
    assign link_coord   = link_flit[FLIT_COORD_LSB +: COORD_W];
    assign link_payload = link_flit[FLIT_PAYLOAD_LSB +: PAYLOAD_W];
    assign link_id      = link_flit[FLIT_ID_LSB +: ID_W];
    assign link_src     = link_flit[FLIT_SRC_LSB +: NODE_W];
    assign link_idx     = link_flit[FLIT_IDX_LSB +: IDX_W];

    assign slot_sel  = link_src[SRC_W-1:0];
    assign last_flit = link_valid && (link_idx == LAST_FLIT);

    // Slot contents with the arriving slice in place
    always_comb begin
        merged = slot[slot_sel];
        merged[(FLITS_PER_PACKET - 1 - int'(link_idx)) * PAYLOAD_W +: PAYLOAD_W] =
            link_payload;
    end

    always_ff @(posedge clk) begin
        if (link_valid) begin
            slot[slot_sel] <= merged;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            deliver_valid <= 1'b0;
        end else begin
            deliver_valid <= last_flit;
        end
    end

    // Header fields come from the last flit
    always_ff @(posedge clk) begin
        if (last_flit) begin
            deliver_data <= merged;
            deliver_src  <= link_src;
            deliver_dest <= link_coord;
            deliver_id   <= link_id;
        end
    end

endmodule

// ==== logic/flit_arbiter.sv ====
`timescale 1ns/1ns

module flit_arbiter import noc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [SRC_COUNT-1:0]  flit_valid,
    input  flit_t [SRC_COUNT-1:0] flit,
    output logic [SRC_COUNT-1:0]  take,
    output logic                  link_valid,
    output flit_t                 link_flit
);

    logic [SRC_W-1:0] rr_ptr;
    logic [SRC_W-1:0] grant;
    logic             found;

    // Scan from the pointer, first requester wins
    always_comb begin
        int cand;
        found = 1'b0;
        grant = rr_ptr;
        cand  = 0;
        for (int i = 0; i < SRC_COUNT; i++) begin
            cand = (int'(rr_ptr) + i) % SRC_COUNT;
            if (!found && flit_valid[cand]) begin
                found = 1'b1;
                grant = SRC_W'(cand);
            end
        end
    end

    always_comb begin
        take        = '0;
        take[grant] = found;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr     <= '0;
            link_valid <= 1'b0;
        end else begin
            link_valid <= found;
            if (found) begin
                // Next search starts just past the winner
                if (grant == SRC_W'(SRC_COUNT - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= grant + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            link_flit <= flit[grant];
        end
    end

endmodule

// ==== logic/packet_splitter.sv ====
`timescale 1ns/1ns

module packet_splitter import noc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  node_id_t   node_id,
    input  logic       packet_valid,
    input  packet_t    packet_data,
    input  node_id_t   packet_dest,
    input  packet_id_t packet_id,
    output logic       full,
    output logic       flit_valid,
    output flit_t      flit,
    input  logic       take
);

    packet_t    pay_q   [QUEUE_DEPTH];
    coord_t     coord_q [QUEUE_DEPTH];
    packet_id_t id_q    [QUEUE_DEPTH];

    logic [QPTR_W-1:0] head;
    logic [QPTR_W-1:0] tail;
    logic [QPTR_W:0]   count;
    flit_idx_t         flit_idx;
    coord_t            dest_coord;
    node_id_t          dest_col;
    node_id_t          dest_row;
    logic              push;
    logic              advance;
    logic              pop;

    // Flit 0 carries the top slice of the packet
    function automatic flit_t make_flit(logic [QPTR_W-1:0] slot, flit_idx_t idx);
        payload_t slice;
        slice = pay_q[slot][(FLITS_PER_PACKET - 1 - int'(idx)) * PAYLOAD_W +: PAYLOAD_W];
        return {coord_q[slot], slice, id_q[slot], node_id, idx};
    endfunction

    // 3x3 mesh: column in 3:2, row in 1:0
    always_comb begin
        dest_col = node_id_t'(packet_dest % MESH_DIM);
        dest_row = node_id_t'(packet_dest / MESH_DIM);
        if (packet_dest < NODE_COUNT) begin
            dest_coord = {dest_col[1:0], dest_row[1:0]};
        end else begin
            dest_coord = '1;
        end
    end

    assign full    = (count == QUEUE_DEPTH);
    assign push    = packet_valid && !full;
    assign advance = flit_valid && take;
    assign pop     = advance && (flit_idx == LAST_FLIT);

    always_ff @(posedge clk) begin
        if (push) begin
            pay_q[tail]   <= packet_data;
            coord_q[tail] <= dest_coord;
            id_q[tail]    <= packet_id;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Presented flit state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flit_valid <= 1'b0;
            flit_idx   <= '0;
        end else if (advance) begin
            if (pop) begin
                flit_idx   <= '0;
                flit_valid <= (count > 1);
            end else begin
                flit_idx <= flit_idx + 1'b1;
            end
        end else if (!flit_valid && count != 0) begin
            flit_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (pop) begin
                flit <= make_flit(head + 1'b1, '0);
            end else begin
                flit <= make_flit(head, flit_idx + 1'b1);
            end
        end else if (!flit_valid) begin
            flit <= make_flit(head, '0);
        end
    end

endmodule

// ==== logic/noc_pkg.sv ====
package noc_pkg;

    // Mesh and slice sizes
    localparam int NODE_COUNT       = 9;
    localparam int MESH_DIM         = 3;
    localparam int SRC_COUNT        = 3;
    localparam int QUEUE_DEPTH      = 4;
    localparam int FLITS_PER_PACKET = 4;

    localparam int NODE_W    = 4;
    localparam int COORD_W   = 4;
    localparam int PAYLOAD_W = 17;
    localparam int PACKET_W  = PAYLOAD_W * FLITS_PER_PACKET;
    localparam int ID_W      = 5;
    localparam int IDX_W     = 2;
    localparam int FLIT_W    = COORD_W + PAYLOAD_W + ID_W + NODE_W + IDX_W;

    localparam int SRC_W  = $clog2(SRC_COUNT);
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [NODE_W-1:0]    node_id_t;
    typedef logic [COORD_W-1:0]   coord_t;
    typedef logic [PACKET_W-1:0]  packet_t;
    typedef logic [PAYLOAD_W-1:0] payload_t;
    typedef logic [ID_W-1:0]      packet_id_t;
    typedef logic [IDX_W-1:0]     flit_idx_t;
    typedef logic [FLIT_W-1:0]    flit_t;

    // Flit field positions, coordinate at the top
    localparam int FLIT_IDX_LSB     = 0;
    localparam int FLIT_SRC_LSB     = FLIT_IDX_LSB + IDX_W;
    localparam int FLIT_ID_LSB      = FLIT_SRC_LSB + NODE_W;
    localparam int FLIT_PAYLOAD_LSB = FLIT_ID_LSB + ID_W;
    localparam int FLIT_COORD_LSB   = FLIT_PAYLOAD_LSB + PAYLOAD_W;

    localparam flit_idx_t LAST_FLIT = flit_idx_t'(FLITS_PER_PACKET - 1);

endpackage
